//--- dv/core_trace.txt
# P <instruction word>, in fetch order from the reset PC
# C <pc> <inst> <we> <rd> <wdata>, expected commits in order; wdata ignored when we is 0
P 123450B7
P 67808113
P FFF00193
P 0FF14213
P 00F0E293
P 7F01F313
P 004103B3
P 40730433
P 003444B3
P 0062E533
P 009575B3
P 00508013
P 0010A613
P 0000B683
P 00B00633
P FFF64693
P FEDCB737
P 00D707B3
P 0F07F813
C 80000000 123450B7 1 01 0000000012345000
C 80000004 67808113 1 02 0000000012345678
C 80000008 FFF00193 1 03 FFFFFFFFFFFFFFFF
C 8000000C 0FF14213 1 04 0000000012345687
C 80000010 00F0E293 1 05 000000001234500F
C 80000014 7F01F313 1 06 00000000000007F0
C 80000018 004103B3 1 07 000000002468ACFF
C 8000001C 40730433 1 08 FFFFFFFFDB975AF1
C 80000020 003444B3 1 09 000000002468A50E
C 80000024 0062E533 1 0A 00000000123457FF
C 80000028 009575B3 1 0B 000000000020050E
C 8000002C 00508013 0 00 0000000000000000
C 80000030 0010A613 0 0C 0000000000000000
C 80000034 0000B683 0 0D 0000000000000000
C 80000038 00B00633 1 0C 000000000020050E
C 8000003C FFF64693 1 0D FFFFFFFFFFDFFAF1
C 80000040 FEDCB737 1 0E FFFFFFFFFEDCB000
C 80000044 00D707B3 1 0F FFFFFFFFFEBCAAF1
C 80000048 0F07F813 1 10 00000000000000F0

//--- flist.f
+incdir+common
common/isa_pkg.sv
common/pipe_pkg.sv
verilog/ifu.sv
verilog/idu.sv
verilog/regs.sv
verilog/exu.sv
verilog/core.sv
dv/core_sva.sv
dv/core_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Icommon
TOP       = core_tb
FLIST     = flist.f

SRCS := $(shell grep -v '^+' $(FLIST)) $(wildcard common/*.svh)
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

//--- dv/core_tb.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module core_tb;

    localparam int             COMMIT_TIMEOUT = 50;
    localparam int             COMMIT_LATENCY = 3;
    // ADDI x0, x0, 0
    localparam isa_pkg::inst_t NOP_WORD       = 32'h0000_0013;

    logic               clk;
    logic               rst_n_i;
    logic               ar_valid_o;
    logic               ar_ready_i;
    pipe_pkg::addr_t    ar_addr_o;
    logic               r_valid_i;
    logic               r_ready_o;
    isa_pkg::inst_t     r_data_i;
    logic               commit_valid_o;
    pipe_pkg::addr_t    commit_pc_o;
    isa_pkg::inst_t     commit_inst_o;
    logic               commit_we_o;
    isa_pkg::reg_idx_t  commit_rd_o;
    isa_pkg::xword_t    commit_wdata_o;

    // program image and expected commit records
    isa_pkg::inst_t     prog[$];
    pipe_pkg::addr_t    exp_pc[$];
    isa_pkg::inst_t     exp_inst[$];
    logic               exp_we[$];
    isa_pkg::reg_idx_t  exp_rd[$];
    isa_pkg::xword_t    exp_wdata[$];

    integer             seed;
    int                 cycle;
    logic               first_r_seen;
    int                 first_r_cycle;

    core i_core (
        .clk            (clk           ),
        .rst_n_i        (rst_n_i       ),
        .ar_valid_o     (ar_valid_o    ),
        .ar_ready_i     (ar_ready_i    ),
        .ar_addr_o      (ar_addr_o     ),
        .r_valid_i      (r_valid_i     ),
        .r_ready_o      (r_ready_o     ),
        .r_data_i       (r_data_i      ),
        .commit_valid_o (commit_valid_o),
        .commit_pc_o    (commit_pc_o   ),
        .commit_inst_o  (commit_inst_o ),
        .commit_we_o    (commit_we_o   ),
        .commit_rd_o    (commit_rd_o   ),
        .commit_wdata_o (commit_wdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin : edge_count
        cycle = 0;
        forever begin
            @(posedge clk);
            cycle <= cycle + 1;
        end
    end

    // ****************************************
    // helpers
    // ****************************************
    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    function int pick_delay();
        return $unsigned($random(seed)) % 4;
    endfunction

    // word index counts from the reset PC with a nop past the end
    function automatic isa_pkg::inst_t fetch_word(input pipe_pkg::addr_t addr);
        pipe_pkg::addr_t idx;
        idx = (addr - `RESET_PC) >> 2;
        if (idx < prog.size()) begin
            return prog[idx];
        end
        return NOP_WORD;
    endfunction

    task automatic load_trace();
        int                 fd;
        int                 n;
        string              line;
        isa_pkg::inst_t     word;
        pipe_pkg::addr_t    pc_f;
        isa_pkg::inst_t     inst_f;
        logic               we_f;
        isa_pkg::reg_idx_t  rd_f;
        isa_pkg::xword_t    wd_f;
        fd = $fopen("dv/core_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file dv/core_trace.txt");
            abort_run();
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 0 && line[0] == "P") begin
                n = $sscanf(line, "P %h", word);
                if (n != 1) begin
                    $display("malformed program line in trace: %s", line);
                    abort_run();
                end
                prog.push_back(word);
            end else if (line.len() > 0 && line[0] == "C") begin
                n = $sscanf(line, "C %h %h %h %h %h", pc_f, inst_f, we_f, rd_f, wd_f);
                if (n != 5) begin
                    $display("malformed commit line in trace: %s", line);
                    abort_run();
                end
                exp_pc.push_back(pc_f);
                exp_inst.push_back(inst_f);
                exp_we.push_back(we_f);
                exp_rd.push_back(rd_f);
                exp_wdata.push_back(wd_f);
            end
        end
        $fclose(fd);
        if (prog.size() == 0 || exp_pc.size() == 0) begin
            $display("trace file holds no program or no commit records");
            abort_run();
        end
    endtask

    // ****************************************
    // compare tasks
    // ****************************************
    task automatic check_pc(input pipe_pkg::addr_t got, input pipe_pkg::addr_t exp);
        if (got !== exp) begin
            $display("Error: commit_pc_o is 0x%h, expected 0x%h", got, exp);
            abort_run();
        end
    endtask

    task automatic check_inst(input isa_pkg::inst_t got, input isa_pkg::inst_t exp);
        if (got !== exp) begin
            $display("Error: commit_inst_o is 0x%h, expected 0x%h", got, exp);
            abort_run();
        end
    endtask

    task automatic check_we(input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: commit_we_o is 0x%h, expected 0x%h", got, exp);
            abort_run();
        end
    endtask

    task automatic check_rd(input isa_pkg::reg_idx_t got, input isa_pkg::reg_idx_t exp);
        if (got !== exp) begin
            $display("Error: commit_rd_o is 0x%h, expected 0x%h", got, exp);
            abort_run();
        end
    endtask

    task automatic check_wdata(input isa_pkg::xword_t got, input isa_pkg::xword_t exp);
        if (got !== exp) begin
            $display("Error: commit_wdata_o is 0x%h, expected 0x%h", got, exp);
            abort_run();
        end
    endtask

    task automatic wait_commit();
        int waited;
        waited = 0;
        @(posedge clk);
        while (commit_valid_o !== 1'b1 && waited < COMMIT_TIMEOUT) begin
            waited++;
            @(posedge clk);
        end
        if (commit_valid_o !== 1'b1) begin
            $display("no commit arrived within %0d cycles", COMMIT_TIMEOUT);
            abort_run();
        end
    endtask

    task automatic check_first_latency();
        int gap;
        gap = cycle - first_r_cycle;
        if (!first_r_seen || gap != COMMIT_LATENCY) begin
            $display("first commit came %0d edges after its fetch, expected %0d",
                     gap, COMMIT_LATENCY);
            abort_run();
        end
    endtask

    // ****************************************
    // AXI4-Lite read responder
    // ****************************************
    initial begin : mem_responder
        int                 ar_left;
        int                 r_left;
        logic               r_armed;
        pipe_pkg::addr_t    r_addr;
        seed          = 68367;
        ar_ready_i    = 1'b0;
        r_valid_i     = 1'b0;
        r_data_i      = '0;
        first_r_seen  = 1'b0;
        first_r_cycle = 0;
        ar_left       = 0;
        r_left        = 0;
        r_armed       = 1'b0;
        r_addr        = '0;
        forever begin
            @(posedge clk);
            if (!rst_n_i) begin
                ar_ready_i <= 1'b0;
                r_valid_i  <= 1'b0;
                ar_left    = pick_delay();
                r_armed    = 1'b0;
            end else begin
                // ready may come up before the next request
                if (ar_valid_o && ar_ready_i) begin
                    r_addr     = ar_addr_o;
                    r_left     = pick_delay();
                    r_armed    = 1'b1;
                    ar_left    = pick_delay();
                    ar_ready_i <= (ar_left == 0);
                end else if (!ar_ready_i) begin
                    if (ar_left == 0) begin
                        ar_ready_i <= 1'b1;
                    end else begin
                        ar_left = ar_left - 1;
                    end
                end
                if (r_valid_i && r_ready_o) begin
                    r_valid_i <= 1'b0;
                    if (!first_r_seen) begin
                        first_r_seen  = 1'b1;
                        first_r_cycle = cycle;
                    end
                end else if (r_armed) begin
                    if (r_left == 0) begin
                        r_valid_i <= 1'b1;
                        r_data_i  <= fetch_word(r_addr);
                        r_armed   = 1'b0;
                    end else begin
                        r_left = r_left - 1;
                    end
                end
            end
        end
    end

    // ****************************************
    // main sequence
    // ****************************************
    initial begin : main_seq
        int i;
        rst_n_i = 1'b0;
        load_trace();
        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;
        for (i = 0; i < exp_pc.size(); i++) begin
            wait_commit();
            if (i == 0) begin
                check_first_latency();
            end
            check_pc(commit_pc_o, exp_pc[i]);
            check_inst(commit_inst_o, exp_inst[i]);
            check_we(commit_we_o, exp_we[i]);
            check_rd(commit_rd_o, exp_rd[i]);
            // result only matters when a register is written
            if (exp_we[i]) begin
                check_wdata(commit_wdata_o, exp_wdata[i]);
            end
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- dv/core_sva.sv
`timescale 1ns/1ps

module core_sva (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                ar_valid_i,
    input  logic                ar_ready_i,
    input  pipe_pkg::addr_t     ar_addr_i,
    input  logic                r_ready_i,
    input  logic                commit_valid_i,
    input  logic                commit_we_i,
    input  isa_pkg::reg_idx_t   commit_rd_i
);

    // ****************************************
    // fetch handshake
    // ****************************************

    // request held until accepted
    ar_hold_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        (ar_valid_i && !ar_ready_i) |=> (ar_valid_i && $stable(ar_addr_i)))
        else $error("ar_valid_o dropped or ar_addr_o changed before ar_ready_i");

    // one read at a time
    ar_r_excl_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(r_ready_i && ar_valid_i))
        else $error("r_ready_o and ar_valid_o high together");

    // ****************************************
    // commit port and reset
    // ****************************************
    no_x0_write_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        commit_we_i |-> (commit_rd_i != '0))
        else $error("commit_we_o high with commit_rd_o zero");

    reset_quiet_a: assert property (@(posedge clk)
        (!rst_n_i && ($past(rst_n_i) == 1'b0))
            |-> (!ar_valid_i && !r_ready_i && !commit_valid_i && !commit_we_i))
        else $error("control output high during reset");

endmodule

bind core core_sva i_core_sva (
    .clk            (clk           ),
    .rst_n_i        (rst_n_i       ),
    .ar_valid_i     (ar_valid_o    ),
    .ar_ready_i     (ar_ready_i    ),
    .ar_addr_i      (ar_addr_o     ),
    .r_ready_i      (r_ready_o     ),
    .commit_valid_i (commit_valid_o),
    .commit_we_i    (commit_we_o   ),
    .commit_rd_i    (commit_rd_o   )
);

//--- verilog/core.sv
`timescale 1ns/1ps

module core (
    input  logic                clk,
    input  logic                rst_n_i,
    output logic                ar_valid_o,
    input  logic                ar_ready_i,
    output pipe_pkg::addr_t     ar_addr_o,
    input  logic                r_valid_i,
    output logic                r_ready_o,
    input  isa_pkg::inst_t      r_data_i,
    output logic                commit_valid_o,
    output pipe_pkg::addr_t     commit_pc_o,
    output isa_pkg::inst_t      commit_inst_o,
    output logic                commit_we_o,
    output isa_pkg::reg_idx_t   commit_rd_o,
    output isa_pkg::xword_t     commit_wdata_o
);

    // IF -> ID
    logic               if_valid;
    pipe_pkg::addr_t    if_pc;
    isa_pkg::inst_t     if_inst;

    // ID <-> register file
    isa_pkg::reg_idx_t  rs1;
    isa_pkg::reg_idx_t  rs2;
    isa_pkg::xword_t    rs1_data;
    isa_pkg::xword_t    rs2_data;

    // ID -> EX
    logic               ex_valid;
    pipe_pkg::addr_t    ex_pc;
    isa_pkg::inst_t     ex_inst;
    isa_pkg::alu_op_e   ex_alu_op;
    isa_pkg::xword_t    ex_op1;
    isa_pkg::xword_t    ex_op2;
    logic               ex_we;
    isa_pkg::reg_idx_t  ex_rd;

    // EX forwarding back to ID
    logic               fwd_we;
    isa_pkg::reg_idx_t  fwd_rd;
    isa_pkg::xword_t    fwd_data;

    ifu i_ifu (
        .clk        (clk       ),
        .rst_n_i    (rst_n_i   ),
        .ar_ready_i (ar_ready_i),
        .r_valid_i  (r_valid_i ),
        .r_data_i   (r_data_i  ),
        .ar_valid_o (ar_valid_o),
        .ar_addr_o  (ar_addr_o ),
        .r_ready_o  (r_ready_o ),
        .if_valid_o (if_valid  ),
        .if_pc_o    (if_pc     ),
        .if_inst_o  (if_inst   )
    );

    // ****************************************
    // decode takes WB forwarding off the commit port
    // ****************************************
    idu i_idu (
        .clk           (clk           ),
        .rst_n_i       (rst_n_i       ),
        .if_valid_i    (if_valid      ),
        .if_pc_i       (if_pc         ),
        .if_inst_i     (if_inst       ),
        .rs1_o         (rs1           ),
        .rs2_o         (rs2           ),
        .rs1_data_i    (rs1_data      ),
        .rs2_data_i    (rs2_data      ),
        .ex_fwd_we_i   (fwd_we        ),
        .ex_fwd_rd_i   (fwd_rd        ),
        .ex_fwd_data_i (fwd_data      ),
        .wb_fwd_we_i   (commit_we_o   ),
        .wb_fwd_rd_i   (commit_rd_o   ),
        .wb_fwd_data_i (commit_wdata_o),
        .ex_valid_o    (ex_valid      ),
        .ex_pc_o       (ex_pc         ),
        .ex_inst_o     (ex_inst       ),
        .ex_alu_op_o   (ex_alu_op     ),
        .ex_op1_o      (ex_op1        ),
        .ex_op2_o      (ex_op2        ),
        .ex_we_o       (ex_we         ),
        .ex_rd_o       (ex_rd         )
    );

    regs i_regs (
        .clk      (clk           ),
        .raddr1_i (rs1           ),
        .raddr2_i (rs2           ),
        .waddr_i  (commit_rd_o   ),
        .wen_i    (commit_we_o   ),
        .wdata_i  (commit_wdata_o),
        .rdata1_o (rs1_data      ),
        .rdata2_o (rs2_data      )
    );

    exu i_exu (
        .clk            (clk           ),
        .rst_n_i        (rst_n_i       ),
        .ex_valid_i     (ex_valid      ),
        .ex_pc_i        (ex_pc         ),
        .ex_inst_i      (ex_inst       ),
        .ex_alu_op_i    (ex_alu_op     ),
        .ex_op1_i       (ex_op1        ),
        .ex_op2_i       (ex_op2        ),
        .ex_we_i        (ex_we         ),
        .ex_rd_i        (ex_rd         ),
        .fwd_we_o       (fwd_we        ),
        .fwd_rd_o       (fwd_rd        ),
        .fwd_data_o     (fwd_data      ),
        .commit_valid_o (commit_valid_o),
        .commit_pc_o    (commit_pc_o   ),
        .commit_inst_o  (commit_inst_o ),
        .commit_we_o    (commit_we_o   ),
        .commit_rd_o    (commit_rd_o   ),
        .commit_wdata_o (commit_wdata_o)
    );

endmodule

//--- verilog/exu.sv
`timescale 1ns/1ps

module exu (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                ex_valid_i,
    input  pipe_pkg::addr_t     ex_pc_i,
    input  isa_pkg::inst_t      ex_inst_i,
    input  isa_pkg::alu_op_e    ex_alu_op_i,
    input  isa_pkg::xword_t     ex_op1_i,
    input  isa_pkg::xword_t     ex_op2_i,
    input  logic                ex_we_i,
    input  isa_pkg::reg_idx_t   ex_rd_i,
    output logic                fwd_we_o,
    output isa_pkg::reg_idx_t   fwd_rd_o,
    output isa_pkg::xword_t     fwd_data_o,
    output logic                commit_valid_o,
    output pipe_pkg::addr_t     commit_pc_o,
    output isa_pkg::inst_t      commit_inst_o,
    output logic                commit_we_o,
    output isa_pkg::reg_idx_t   commit_rd_o,
    output isa_pkg::xword_t     commit_wdata_o
);

    isa_pkg::xword_t alu_res;

    // ****************************************
    // ALU
    // ****************************************
    always_comb begin
        case (ex_alu_op_i)
            isa_pkg::ALU_ADD:    alu_res = ex_op1_i + ex_op2_i;
            isa_pkg::ALU_SUB:    alu_res = ex_op1_i - ex_op2_i;
            isa_pkg::ALU_XOR:    alu_res = ex_op1_i ^ ex_op2_i;
            isa_pkg::ALU_OR:     alu_res = ex_op1_i | ex_op2_i;
            isa_pkg::ALU_AND:    alu_res = ex_op1_i & ex_op2_i;
            isa_pkg::ALU_PASS_B: alu_res = ex_op2_i;
            default:             alu_res = '0;
        endcase
    end

    // result back to decode before it is registered
    assign fwd_we_o   = ex_valid_i && ex_we_i;
    assign fwd_rd_o   = ex_rd_i;
    assign fwd_data_o = alu_res;

    // EX/WB doubles as the commit port
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            commit_valid_o <= 1'b0;
            commit_we_o    <= 1'b0;
        end else begin
            commit_valid_o <= ex_valid_i;
            commit_we_o    <= ex_valid_i && ex_we_i;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid_i) begin
            commit_pc_o    <= ex_pc_i;
            commit_inst_o  <= ex_inst_i;
            commit_rd_o    <= ex_rd_i;
            commit_wdata_o <= alu_res;
        end
    end

endmodule

//--- verilog/regs.sv
`timescale 1ns/1ps

module regs (
    input  logic                clk,
    input  isa_pkg::reg_idx_t   raddr1_i,
    input  isa_pkg::reg_idx_t   raddr2_i,
    input  isa_pkg::reg_idx_t   waddr_i,
    input  logic                wen_i,
    input  isa_pkg::xword_t     wdata_i,
    output isa_pkg::xword_t     rdata1_o,
    output isa_pkg::xword_t     rdata2_o
);

    // x0 has no storage
    isa_pkg::xword_t rf [1:31];

    // write lands at the edge closing the commit cycle
    always_ff @(posedge clk) begin
        if (wen_i) begin
            rf[waddr_i] <= wdata_i;
        end
    end

    // combinational reads
    assign rdata1_o = (raddr1_i == '0) ? '0 : rf[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : rf[raddr2_i];

endmodule

//--- verilog/idu.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module idu (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                if_valid_i,
    input  pipe_pkg::addr_t     if_pc_i,
    input  isa_pkg::inst_t      if_inst_i,
    output isa_pkg::reg_idx_t   rs1_o,
    output isa_pkg::reg_idx_t   rs2_o,
    input  isa_pkg::xword_t     rs1_data_i,
    input  isa_pkg::xword_t     rs2_data_i,
    input  logic                ex_fwd_we_i,
    input  isa_pkg::reg_idx_t   ex_fwd_rd_i,
    input  isa_pkg::xword_t     ex_fwd_data_i,
    input  logic                wb_fwd_we_i,
    input  isa_pkg::reg_idx_t   wb_fwd_rd_i,
    input  isa_pkg::xword_t     wb_fwd_data_i,
    output logic                ex_valid_o,
    output pipe_pkg::addr_t     ex_pc_o,
    output isa_pkg::inst_t      ex_inst_o,
    output isa_pkg::alu_op_e    ex_alu_op_o,
    output isa_pkg::xword_t     ex_op1_o,
    output isa_pkg::xword_t     ex_op2_o,
    output logic                ex_we_o,
    output isa_pkg::reg_idx_t   ex_rd_o
);

    isa_pkg::opcode_e   opcode;
    isa_pkg::funct3_e   funct3;
    logic [6:0]         funct7;
    isa_pkg::reg_idx_t  rd;
    isa_pkg::xword_t    imm_i;
    isa_pkg::xword_t    imm_u;
    isa_pkg::xword_t    src1;
    isa_pkg::xword_t    src2;
    isa_pkg::alu_op_e   alu_op;
    isa_pkg::xword_t    op1;
    isa_pkg::xword_t    op2;
    logic               we;

    // youngest result wins, then WB, then the register file
    // a set write enable already implies rd is not x0
    function automatic isa_pkg::xword_t fwd_pick(
        input isa_pkg::reg_idx_t rs,
        input isa_pkg::xword_t   rf_data
    );
        if (ex_fwd_we_i && (ex_fwd_rd_i == rs)) begin
            return ex_fwd_data_i;
        end
        if (wb_fwd_we_i && (wb_fwd_rd_i == rs)) begin
            return wb_fwd_data_i;
        end
        return rf_data;
    endfunction

    // ****************************************
    // field extraction
    // ****************************************
    assign opcode = isa_pkg::opcode_e'(if_inst_i[6:0]);
    assign funct3 = isa_pkg::funct3_e'(if_inst_i[14:12]);
    assign funct7 = if_inst_i[31:25];
    assign rd     = if_inst_i[11:7];
    assign rs1_o  = if_inst_i[19:15];
    assign rs2_o  = if_inst_i[24:20];

    assign imm_i = {{(`XLEN-12){if_inst_i[31]}}, if_inst_i[31:20]};
    assign imm_u = {{(`XLEN-32){if_inst_i[31]}}, if_inst_i[31:12], 12'b0};

    always_comb begin
        src1 = fwd_pick(rs1_o, rs1_data_i);
        src2 = fwd_pick(rs2_o, rs2_data_i);
    end

    // ****************************************
    // decode
    // ****************************************
    always_comb begin
        alu_op = isa_pkg::ALU_ADD;
        op1    = src1;
        op2    = imm_i;
        we     = 1'b0;
        case (opcode)
            isa_pkg::OPC_LUI: begin
                alu_op = isa_pkg::ALU_PASS_B;
                op1    = '0;
                op2    = imm_u;
                we     = 1'b1;
            end
            isa_pkg::OPC_OP_IMM: begin
                we = 1'b1;
                case (funct3)
                    isa_pkg::F3_ADD: alu_op = isa_pkg::ALU_ADD;
                    isa_pkg::F3_XOR: alu_op = isa_pkg::ALU_XOR;
                    isa_pkg::F3_OR:  alu_op = isa_pkg::ALU_OR;
                    isa_pkg::F3_AND: alu_op = isa_pkg::ALU_AND;
                    default:         we     = 1'b0;
                endcase
            end
            isa_pkg::OPC_OP: begin
                op2 = src2;
                we  = (funct7 == isa_pkg::F7_BASE);
                case (funct3)
                    isa_pkg::F3_ADD: begin
                        // SUB shares funct3 with ADD
                        if (funct7 == isa_pkg::F7_SUB) begin
                            alu_op = isa_pkg::ALU_SUB;
                            we     = 1'b1;
                        end
                    end
                    isa_pkg::F3_XOR: alu_op = isa_pkg::ALU_XOR;
                    isa_pkg::F3_OR:  alu_op = isa_pkg::ALU_OR;
                    isa_pkg::F3_AND: alu_op = isa_pkg::ALU_AND;
                    default:         we     = 1'b0;
                endcase
            end
            default: begin
                we = 1'b0;
            end
        endcase
        // x0 is never written
        if (rd == '0) begin
            we = 1'b0;
        end
    end

    // ID/EX control
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_valid_o <= 1'b0;
            ex_we_o    <= 1'b0;
        end else begin
            ex_valid_o <= if_valid_i;
            ex_we_o    <= if_valid_i && we;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        if (if_valid_i) begin
            ex_pc_o     <= if_pc_i;
            ex_inst_o   <= if_inst_i;
            ex_alu_op_o <= alu_op;
            ex_op1_o    <= op1;
            ex_op2_o    <= op2;
            ex_rd_o     <= rd;
        end
    end

endmodule

//--- verilog/ifu.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module ifu (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                ar_ready_i,
    input  logic                r_valid_i,
    input  isa_pkg::inst_t      r_data_i,
    output logic                ar_valid_o,
    output pipe_pkg::addr_t     ar_addr_o,
    output logic                r_ready_o,
    output logic                if_valid_o,
    output pipe_pkg::addr_t     if_pc_o,
    output isa_pkg::inst_t      if_inst_o
);

    pipe_pkg::fetch_state_e state_q;
    pipe_pkg::addr_t        pc_q;

    // address stays put until AR completes
    assign ar_addr_o = pc_q;

    // ****************************************
    // fetch FSM with one read in flight
    // ****************************************
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= pipe_pkg::FS_REQ;
            pc_q       <= `RESET_PC;
            ar_valid_o <= 1'b0;
            r_ready_o  <= 1'b0;
            if_valid_o <= 1'b0;
        end else begin
            if_valid_o <= 1'b0;
            case (state_q)
                pipe_pkg::FS_REQ: begin
                    if (ar_valid_o && ar_ready_i) begin
                        ar_valid_o <= 1'b0;
                        r_ready_o  <= 1'b1;
                        state_q    <= pipe_pkg::FS_WAIT;
                    end else begin
                        ar_valid_o <= 1'b1;
                    end
                end
                pipe_pkg::FS_WAIT: begin
                    // hand the word to decode and ask for the next one
                    if (r_valid_i && r_ready_o) begin
                        r_ready_o  <= 1'b0;
                        ar_valid_o <= 1'b1;
                        pc_q       <= pc_q + 'd4;
                        if_valid_o <= 1'b1;
                        state_q    <= pipe_pkg::FS_REQ;
                    end
                end
                default: begin
                    state_q <= pipe_pkg::FS_REQ;
                end
            endcase
        end
    end

    // IF/ID payload
    always_ff @(posedge clk) begin
        if (r_valid_i && r_ready_o) begin
            if_pc_o   <= pc_q;
            if_inst_o <= r_data_i;
        end
    end

endmodule

//--- common/pipe_pkg.sv
`include "core_settings.svh"

package pipe_pkg;

    // fetch bus address
    typedef logic [`ADDR_W-1:0] addr_t;

    // ****************************************
    // fetch FSM
    // ****************************************

    // FS_REQ drives AR, FS_WAIT waits on R
    typedef enum logic [1:0] {
        FS_REQ  = 2'd0,
        FS_WAIT = 2'd1
    } fetch_state_e;

endpackage

//--- common/isa_pkg.sv
`include "core_settings.svh"

package isa_pkg;

    typedef logic [`XLEN-1:0]      xword_t;
    typedef logic [`ILEN-1:0]      inst_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    // major opcodes in inst[6:0]
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // operations the ALU knows
    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_XOR    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_AND    = 3'd4,
        ALU_PASS_B = 3'd5
    } alu_op_e;

    // funct3 in inst[14:12]
    typedef enum logic [2:0] {
        F3_ADD = 3'b000,
        F3_XOR = 3'b100,
        F3_OR  = 3'b110,
        F3_AND = 3'b111
    } funct3_e;

    // funct7 for register ops
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

endpackage

//--- common/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// ****************************************
// core widths
// ****************************************

// integer data path
`define XLEN      64
// instruction word
`define ILEN      32
// fetch bus address
`define ADDR_W    32
// register index
`define REG_IDX_W 5

// first fetch after reset
`define RESET_PC  32'h8000_0000

`endif
